// ==== design/l2_write_pkg.sv ====
package l2_write_pkg;

    // Bus geometry
    parameter int addr_w = 32;
    parameter logic [2:0] word_size = 3'd2; // AXI size code for 4 bytes per beat

    // Write path controller states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        DMA_AW = 3'd1,
        DMA_W  = 3'd2,
        DMA_R  = 3'd3,
        WRT_W  = 3'd4  // Line burst owned by the write buffer
    } wr_state_t;

    // Write address channel payload
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [7:0]        len;  // Beats minus one
        logic [2:0]        size;
    } aw_chan_t;

    // Write data channel payload
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } w_chan_t;

endpackage

// ==== design/write_buffer.sv ====
module write_buffer
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Line request from the arbiter
    input  logic                          buf_req,
    input  logic [addr_w-1:0]             buf_addr,
    input  logic [(32<<offset_width)-1:0] buf_line,
    output logic                          buf_ok,
    output logic                          buf_busy,
    // AXI write channels
    output aw_chan_t                      aw,
    output logic                          awvalid,
    input  logic                          awready,
    output w_chan_t                       w,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic                          bvalid,
    output logic                          bready
);

    localparam int line_w   = 32 << offset_width;
    localparam int words    = 1 << offset_width;
    localparam int byte_off = offset_width + 2;

    logic                    busy;
    logic                    aw_pend;
    logic                    w_pend;
    logic                    b_wait;
    logic [offset_width-1:0] beat;
    logic [addr_w-1:0]       addr_q;
    logic [line_w-1:0]       line_q;
    logic                    accept;
    logic                    last_beat;

    assign accept    = buf_req && !busy;   // Only an empty buffer takes a line
    assign last_beat = (beat == offset_width'(words - 1));

    // Line payload captured once per burst
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= {buf_addr[addr_w-1:byte_off], {byte_off{1'b0}}};
            line_q <= buf_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            b_wait  <= 1'b0;
            beat    <= '0;
        end else begin
            if (accept) begin
                busy    <= 1'b1;
                aw_pend <= 1'b1;
                beat    <= '0;
            end

            if (aw_pend && awready) begin
                aw_pend <= 1'b0;
                w_pend  <= 1'b1;           // Data follows the address
            end

            if (w_pend && wready) begin
                beat <= beat + 1'b1;
                if (last_beat) begin
                    w_pend <= 1'b0;
                    b_wait <= 1'b1;
                end
            end

            if (b_wait && bvalid) begin
                b_wait <= 1'b0;
                busy   <= 1'b0;            // Free only after the response
            end
        end
    end

    assign buf_ok   = accept;
    assign buf_busy = busy;

    assign aw.addr = addr_q;
    assign aw.len  = 8'(words - 1);
    assign aw.size = word_size;
    assign awvalid = aw_pend;

    assign w.data = line_q[32*beat +: 32]; // Lowest word goes out first
    assign w.strb = 4'hf;
    assign w.last = last_beat;
    assign wvalid = w_pend;

    assign bready = b_wait;

endmodule

// ==== design/write_path_ctrl.sv ====
module write_path_ctrl
    import l2_write_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req,
    input  logic      dma_sign,
    input  logic      buf_busy,
    input  logic      awready,
    input  logic      wready,
    input  logic      bvalid,
    output wr_state_t state
);

    wr_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // Uncached store waits until the buffered line has drained
                if (req && dma_sign && !buf_busy) begin
                    state_nxt = DMA_AW;
                end else if (buf_busy) begin
                    state_nxt = WRT_W;
                end
            end
            DMA_AW: begin
                if (awready) begin
                    state_nxt = DMA_W;
                end
            end
            DMA_W: begin
                if (wready) begin
                    state_nxt = DMA_R;
                end
            end
            DMA_R: begin
                if (bvalid) begin
                    state_nxt = IDLE;      // addr_ok pulses in this cycle
                end
            end
            WRT_W: begin
                if (!buf_busy) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== design/write_arbiter.sv ====
module write_arbiter
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2
) (
    input  wr_state_t                     state,
    // Cache side
    input  logic                          req,
    input  logic                          dma_sign,
    input  logic [2:0]                    size,
    input  logic [3:0]                    wstrb,
    input  logic [addr_w-1:0]             addr,
    input  logic [(32<<offset_width)-1:0] line,
    output logic                          addr_ok,
    // Write buffer side
    output logic                          buf_req,
    output logic [addr_w-1:0]             buf_addr,
    output logic [(32<<offset_width)-1:0] buf_line,
    input  logic                          buf_ok,
    input  aw_chan_t                      buf_aw,
    input  logic                          buf_awvalid,
    input  w_chan_t                       buf_w,
    input  logic                          buf_wvalid,
    input  logic                          buf_bready,
    output logic                          buf_awready,
    output logic                          buf_wready,
    output logic                          buf_bvalid,
    // AXI port
    output aw_chan_t                      aw,
    output logic                          awvalid,
    input  logic                          awready,
    output w_chan_t                       w,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic                          bvalid,
    output logic                          bready
);

    always_comb begin
        addr_ok     = 1'b0;
        buf_req     = 1'b0;
        buf_addr    = '0;
        buf_line    = '0;
        buf_awready = 1'b0;
        buf_wready  = 1'b0;
        buf_bvalid  = 1'b0;
        aw          = '0;
        awvalid     = 1'b0;
        w           = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;

        case (state)
            IDLE, WRT_W: begin
                buf_req  = req && !dma_sign; // Line writes only
                buf_addr = addr;
                buf_line = line;
                addr_ok  = buf_ok;

                aw      = buf_aw;
                awvalid = buf_awvalid;
                w       = buf_w;
                wvalid  = buf_wvalid;
                bready  = buf_bready;

                buf_awready = awready;
                buf_wready  = wready;
                buf_bvalid  = bvalid;
            end
            DMA_AW: begin
                aw.addr = addr;
                aw.len  = 8'd0;            // Single beat
                aw.size = size;
                awvalid = 1'b1;
            end
            DMA_W: begin
                w.data = line[31:0];
                w.strb = wstrb;
                w.last = 1'b1;
                wvalid = 1'b1;
            end
            DMA_R: begin
                bready  = 1'b1;
                addr_ok = bvalid;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== design/l2_write_path.sv ====
module l2_write_path
    import l2_write_pkg::*;
#(
    parameter int offset_width = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Cache side
    input  logic                          req,
    input  logic                          dma_sign,
    input  logic [2:0]                    size,
    input  logic [3:0]                    wstrb,
    input  logic [addr_w-1:0]             addr,
    input  logic [(32<<offset_width)-1:0] line,
    output logic                          addr_ok,
    // AXI write port
    output aw_chan_t                      aw,
    output logic                          awvalid,
    input  logic                          awready,
    output w_chan_t                       w,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic                          bvalid,
    output logic                          bready
);

    logic                          buf_req;
    logic [addr_w-1:0]             buf_addr;
    logic [(32<<offset_width)-1:0] buf_line;
    logic                          buf_ok;
    logic                          buf_busy;
    aw_chan_t                      buf_aw;
    logic                          buf_awvalid;
    logic                          buf_awready;
    w_chan_t                       buf_w;
    logic                          buf_wvalid;
    logic                          buf_wready;
    logic                          buf_bvalid;
    logic                          buf_bready;
    wr_state_t                     state;

    write_buffer #(
        .offset_width(offset_width)
    ) u_write_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .buf_req (buf_req),
        .buf_addr(buf_addr),
        .buf_line(buf_line),
        .buf_ok  (buf_ok),
        .buf_busy(buf_busy),
        .aw      (buf_aw),
        .awvalid (buf_awvalid),
        .awready (buf_awready),
        .w       (buf_w),
        .wvalid  (buf_wvalid),
        .wready  (buf_wready),
        .bvalid  (buf_bvalid),
        .bready  (buf_bready)
    );

    write_path_ctrl u_write_path_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .dma_sign(dma_sign),
        .buf_busy(buf_busy),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .state   (state)
    );

    write_arbiter #(
        .offset_width(offset_width)
    ) u_write_arbiter (
        .state      (state),
        .req        (req),
        .dma_sign   (dma_sign),
        .size       (size),
        .wstrb      (wstrb),
        .addr       (addr),
        .line       (line),
        .addr_ok    (addr_ok),
        .buf_req    (buf_req),
        .buf_addr   (buf_addr),
        .buf_line   (buf_line),
        .buf_ok     (buf_ok),
        .buf_aw     (buf_aw),
        .buf_awvalid(buf_awvalid),
        .buf_w      (buf_w),
        .buf_wvalid (buf_wvalid),
        .buf_bready (buf_bready),
        .buf_awready(buf_awready),
        .buf_wready (buf_wready),
        .buf_bvalid (buf_bvalid),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready)
    );

endmodule

// ==== testbench/axi_mem_model.sv ====
module axi_mem_model
    import l2_write_pkg::*;
#(
    parameter logic [31:0] seed = 32'h23e6d31c
) (
    input  logic        clk,
    input  logic        rst_n,
    input  aw_chan_t    aw,
    input  logic        awvalid,
    output logic        awready,
    input  w_chan_t     w,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    // Burst bookkeeping for the testbench checks
    output logic [7:0]  cur_len,
    output logic [7:0]  beat_idx
);

    logic [31:0] mem [0:255];
    logic [31:0] lfsr;
    logic [31:0] cur_addr;
    logic        b_pend;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hc3a5_0000 ^ (32'(i) * 32'h0001_0101); // Depends on every address bit
        end
    end

    always @(posedge clk) begin : slave_step
        logic b0;
        logic b1;
        if (!rst_n) begin
            lfsr = seed;
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            b_pend     <= 1'b0;
            cur_len    <= '0;
            beat_idx   <= '0;
            cur_addr   <= '0;
        end else begin
            lfsr = lfsr_step(lfsr);
            b0 = lfsr[0];
            lfsr = lfsr_step(lfsr);
            b1 = lfsr[0];
            awready <= b0 | b1;            // High three cycles in four on average
            lfsr = lfsr_step(lfsr);
            b0 = lfsr[0];
            lfsr = lfsr_step(lfsr);
            b1 = lfsr[0];
            wready <= b0 | b1;

            if (awvalid && awready) begin
                cur_addr   <= aw.addr;
                cur_len    <= aw.len;
                beat_idx   <= '0;
            end

            if (bvalid && bready) begin
                bvalid     <= 1'b0;
            end else if (b_pend && !bvalid) begin
                lfsr = lfsr_step(lfsr);
                if (lfsr[0]) begin
                    bvalid <= 1'b1;
                    b_pend <= 1'b0;
                end
            end

            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (w.strb[b]) begin
                        mem[cur_addr[9:2]][8*b +: 8] = w.data[8*b +: 8];
                    end
                end
                cur_addr <= cur_addr + 32'd4;  // Incrementing burst
                beat_idx <= beat_idx + 8'd1;
                if (w.last) begin
                    b_pend <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_l2_write_path.sv ====
module tb_l2_write_path
    import l2_write_pkg::*;
;

    localparam int n_req = 16;

    logic         clk;
    logic         rst_n;
    logic         rst_q;
    logic         req;
    logic         dma_sign;
    logic [2:0]   size;
    logic [3:0]   wstrb;
    logic [31:0]  addr;
    logic [127:0] line;
    logic         addr_ok;
    aw_chan_t     aw;
    aw_chan_t     aw_q;
    logic         awvalid;
    logic         awready;
    w_chan_t      w;
    w_chan_t      w_q;
    logic         wvalid;
    logic         wready;
    logic         bvalid;
    logic         bready;
    logic [7:0]   cur_len;
    logic [7:0]   beat_idx;
    logic         line_open;
    logic [31:0]  ref_mem [0:255];
    int           errors;
    int           n_issued;
    int           n_ack;

    l2_write_path #(.offset_width(2)) u_l2_write_path (
        .clk(clk), .rst_n(rst_n), .req(req), .dma_sign(dma_sign), .size(size),
        .wstrb(wstrb), .addr(addr), .line(line), .addr_ok(addr_ok),
        .aw(aw), .awvalid(awvalid), .awready(awready), .w(w), .wvalid(wvalid),
        .wready(wready), .bvalid(bvalid), .bready(bready)
    );

    axi_mem_model #(.seed(32'h23e6d31c)) u_mem (
        .clk(clk), .rst_n(rst_n), .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready),
        .cur_len(cur_len), .beat_idx(beat_idx)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // A line stays open from its addr_ok until its burst response
    always @(posedge clk) begin
        rst_q <= rst_n;
        aw_q  <= aw;
        w_q   <= w;
        if (!rst_n) begin
            line_open <= 1'b0;
        end else if (addr_ok && !dma_sign) begin
            line_open <= 1'b1;
        end else if (bvalid && bready) begin
            line_open <= 1'b0;
        end
        if (rst_n && addr_ok) begin
            n_ack <= n_ack + 1;
        end
    end

    task automatic report_error(input string msg);
        errors = errors + 1;
        $display("** Error @%0t: %s", $time, msg);
    endtask

    assert property (@(posedge clk) (!rst_n || !rst_q)
                     |-> !(awvalid || wvalid || bready || addr_ok))
        else report_error($sformatf(
            "awvalid/wvalid/bready/addr_ok expected 0000, got %b%b%b%b",
            awvalid, wvalid, bready, addr_ok));
    assert property (@(posedge clk) disable iff (!rst_n) awvalid && aw.len != 8'd0
                     |-> aw.len == 8'd3 && aw.size == 3'd2 && aw.addr[3:0] == 4'd0)
        else report_error($sformatf(
            "aw len/size/addr expected 3/2/aligned, got %0d/%0d/%h",
            aw.len, aw.size, aw.addr));
    assert property (@(posedge clk) disable iff (!rst_n)
                     wvalid && cur_len != 8'd0 |-> w.strb == 4'hf)
        else report_error($sformatf("w.strb expected f, got %h", w.strb));
    assert property (@(posedge clk) disable iff (!rst_n)
                     wvalid |-> w.last == (beat_idx == cur_len))
        else report_error($sformatf(
            "w.last expected %b, got %b", beat_idx == cur_len, w.last));
    assert property (@(posedge clk) disable iff (!rst_n)
                     awvalid && aw.len == 8'd0 |-> aw.size == size && aw.addr == addr)
        else report_error($sformatf(
            "aw size/addr expected %0d/%h, got %0d/%h", size, addr, aw.size, aw.addr));
    assert property (@(posedge clk) disable iff (!rst_n)
                     awvalid && aw.len == 8'd0 |-> !line_open)
        else report_error("uncached AW issued before the line burst response");
    assert property (@(posedge clk) disable iff (!rst_n)
                     wvalid && cur_len == 8'd0 |-> w.strb == wstrb && w.data == line[31:0])
        else report_error($sformatf(
            "w strb/data expected %h/%h, got %h/%h", wstrb, line[31:0], w.strb, w.data));
    assert property (@(posedge clk) disable iff (!rst_n)
                     addr_ok && dma_sign |-> bvalid && bready)
        else report_error("uncached addr_ok came without a write response");
    assert property (@(posedge clk) disable iff (!rst_n)
                     addr_ok && !dma_sign |-> !line_open)
        else report_error("line acknowledged before the previous burst response");
    assert property (@(posedge clk) disable iff (!rst_n)
                     awvalid && !awready |=> awvalid && aw == aw_q)
        else report_error($sformatf(
            "aw expected %h, got %h (awvalid %b)", aw_q, aw, awvalid));
    assert property (@(posedge clk) disable iff (!rst_n)
                     wvalid && !wready |=> wvalid && w == w_q)
        else report_error($sformatf(
            "w expected %h, got %h (wvalid %b)", w_q, w, wvalid));

    function automatic logic [127:0] make_line(input int n);
        return {32'(n) * 32'h9e3779b9, 32'(n + 1) * 32'h7f4a7c15,
                32'(n + 2) * 32'h94d049bb, 32'(n + 3) * 32'hbf58476d};
    endfunction

    // Holds one request until addr_ok and applies it to the reference memory at issue
    task automatic issue_req(input logic dma, input logic [31:0] a, input logic [127:0] l,
                             input logic [2:0] sz, input logic [3:0] st);
        req      = 1'b1;
        dma_sign = dma;
        addr     = a;
        line     = l;
        size     = sz;
        wstrb    = st;
        n_issued = n_issued + 1;
        if (dma) begin
            for (int b = 0; b < 4; b++) begin
                if (st[b]) begin
                    ref_mem[a[9:2]][8*b +: 8] = l[8*b +: 8];
                end
            end
        end else begin
            for (int k = 0; k < 4; k++) begin
                ref_mem[{a[9:4], 2'(k)}] = l[32*k +: 32];
            end
        end
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req = 1'b0;
    endtask

    initial begin
        #(n_req * 400 * 20);
        $display("Watchdog expired after %0d cycles with requests still pending", n_req * 400);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        errors = 0;
        n_issued = 0;
        n_ack = 0;
        rst_n = 1'b0;
        req = 1'b0;
        dma_sign = 1'b0;
        size = 3'd0;
        wstrb = 4'h0;
        addr = '0;
        line = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = u_mem.mem[i];
        end
        repeat (2) @(posedge clk);
        #2;

        issue_req(1'b0, 32'h40, make_line(1), 3'd2, 4'hf);
        issue_req(1'b0, 32'h80, make_line(7), 3'd2, 4'hf);   // Refused until the first response
        issue_req(1'b1, 32'h85, make_line(11), 3'd0, 4'b0010); // Same line as the burst
        issue_req(1'b0, 32'h104, make_line(13), 3'd2, 4'hf);  // Unaligned line address
        issue_req(1'b1, 32'h106, make_line(17), 3'd1, 4'b1100);
        for (int k = 0; k < 10; k++) begin
            case (k % 3)
                0: issue_req(1'b0, 32'((k * 48) & 'h3f0), make_line(20 + k), 3'd2, 4'hf);
                1: issue_req(1'b1, 32'(((k * 20) & 'h3fc) + (k % 4)), make_line(40 + k),
                             3'd0, 4'(1 << (k % 4)));
                default: issue_req(1'b1, 32'((k * 20) & 'h3fc), make_line(60 + k), 3'd2, 4'hf);
            endcase
        end
        issue_req(1'b1, 32'h3fc, make_line(99), 3'd2, 4'hf); // Completes only after all lines drain
        repeat (2) @(negedge clk);

        for (int i = 0; i < 256; i++) begin
            assert (u_mem.mem[i] == ref_mem[i])
                else report_error($sformatf(
                    "mem[%0d] expected %h, got %h", i, ref_mem[i], u_mem.mem[i]));
        end
        assert (n_ack == n_issued)
            else report_error($sformatf(
                "addr_ok count expected %0d, got %0d", n_issued, n_ack));

        $display("Requests: %0d, errors: %0d", n_issued, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/l2_write_pkg.sv
design/write_buffer.sv
design/write_path_ctrl.sv
design/write_arbiter.sv
design/l2_write_path.sv
testbench/axi_mem_model.sv
testbench/tb_l2_write_path.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_l2_write_path
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(BUILD_DIR)
